//--- rtl/sdCardPkg.sv
`default_nettype none

package sdCardPkg;

    // ==============================
    // Field types
    // ==============================
    typedef logic [5:0]  cmdIndexT;
    typedef logic [6:0]  cmdCodeT;
    typedef logic [31:0] cmdArgT;
    typedef logic [6:0]  crc7T;
    typedef logic [15:0] crc16T;
    typedef logic [15:0] rcaT;

    // ==============================
    // Frame and block sizes
    // ==============================
    localparam int frameLen   = 48;
    // Start, transmission, index and argument bits covered by CRC7
    localparam int bodyLen    = 40;
    localparam int respGap    = 2;
    localparam int datNibbles = 128;
    // Start nibble, payload, CRC16 and end nibble
    localparam int datCycles  = datNibbles + $bits(crc16T) + 2;

    // Feedback taps, x^7 + x^3 + 1 and x^16 + x^12 + x^5 + 1
    localparam crc7T  crc7Poly  = 7'h09;
    localparam crc16T crc16Poly = 16'h1021;

    // ==============================
    // Command codes
    // ==============================
    // Top bit marks an application command after CMD55
    localparam cmdCodeT cmd0   = {1'b0, 6'd0};
    localparam cmdCodeT cmd3   = {1'b0, 6'd3};
    localparam cmdCodeT cmd6   = {1'b0, 6'd6};
    localparam cmdCodeT cmd7   = {1'b0, 6'd7};
    localparam cmdCodeT cmd8   = {1'b0, 6'd8};
    localparam cmdCodeT cmd55  = {1'b0, 6'd55};
    localparam cmdCodeT acmd41 = {1'b1, 6'd41};

    // Response contents
    localparam rcaT         cardRca  = 16'hAAAA;
    localparam logic [15:0] r6Status = 16'h0520;
    localparam cmdArgT      r1Cmd6   = 32'h00000900;
    localparam cmdArgT      r1Cmd7   = 32'h00000700;
    localparam cmdArgT      r1Cmd55  = 32'h00000120;
    // Busy bit set, so the card always reports ready
    localparam cmdArgT      ocrReady = 32'hC1FF8080;
    localparam cmdIndexT    r3Index  = 6'h3F;

endpackage

`default_nettype wire

//--- rtl/sdCmdIf.sv
`default_nettype none

// Checked command frame, receiver to handler
interface sdCmdIf import sdCardPkg::*; ();
    logic     valid;
    logic     bad;
    cmdIndexT index;
    cmdArgT   arg;

    modport rx (output valid, output bad, output index, output arg);
    modport exec (input valid, input bad, input index, input arg);
endinterface

// Response request, handler to both senders
interface sdRespIf import sdCardPkg::*; ();
    logic     start;
    cmdIndexT index;
    cmdArgT   arg;
    logic     noCrc;
    logic     withData;

    modport exec (
        output start, output index, output arg, output noCrc, output withData
    );
    modport send (input start, input index, input arg, input noCrc);
    modport data (input start, input withData);
endinterface

`default_nettype wire

//--- rtl/sdCrc.sv
`default_nettype none

module sdCrc #(
    parameter type crcT = logic [6:0],
    parameter crcT poly = '0
) (
    input  logic clk,
    input  logic rst_,
    input  logic clear,
    input  logic en,
    input  logic din,
    output crcT  crc
);

    logic feedback;
    crcT  shifted;

    // Incoming bit against the register MSB
    assign feedback = din ^ crc[$bits(crcT)-1];
    assign shifted  = {crc[$bits(crcT)-2:0], 1'b0};

    // Feeding the MSB back in turns the register into a plain
    // shifter, which the senders use to clock the CRC out
    always_ff @(posedge clk) begin
        if (!rst_ || clear) begin
            crc <= '0;
        end else if (en) begin
            crc <= shifted ^ (poly & {$bits(crcT){feedback}});
        end
    end

endmodule

`default_nettype wire

//--- rtl/sdCmdReceive.sv
`default_nettype none

module sdCmdReceive import sdCardPkg::*; (
    input  logic clk,
    input  logic rst_,
    input  logic cmdIn,
    input  logic busy,
    sdCmdIf.rx   cmd
);

    logic [frameLen-1:0] frame;
    logic [5:0]          bitCnt;
    logic                active;
    logic                frameDone;
    logic                takeBit;
    logic                frameOk;
    crc7T                ourCrc;

    // Start bit only counts while our own response is off the line
    assign takeBit = active || (!busy && !cmdIn);

    sdCrc #(
        .crcT (crc7T),
        .poly (crc7Poly)
    ) u_crc7 (
        .clk   (clk),
        .rst_  (rst_),
        .clear (!takeBit),
        .en    (takeBit && (bitCnt < 6'(bodyLen))),
        .din   (cmdIn),
        .crc   (ourCrc)
    );

    always_ff @(posedge clk) begin
        if (!rst_) begin
            active    <= 1'b0;
            bitCnt    <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            if (takeBit) begin
                if (bitCnt == 6'(frameLen - 1)) begin
                    active    <= 1'b0;
                    bitCnt    <= '0;
                    frameDone <= 1'b1;
                end else begin
                    active <= 1'b1;
                    bitCnt <= bitCnt + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (takeBit) begin
            frame <= {frame[frameLen-2:0], cmdIn};
        end
    end

    // Layout is preamble, index, argument, CRC7, end bit
    assign frameOk = (frame[47:46] == 2'b01) && (frame[7:1] == ourCrc) && frame[0];

    always_ff @(posedge clk) begin
        if (!rst_) begin
            cmd.valid <= 1'b0;
            cmd.bad   <= 1'b0;
        end else begin
            cmd.valid <= frameDone && frameOk;
            cmd.bad   <= frameDone && !frameOk;
        end
    end

    always_ff @(posedge clk) begin
        if (frameDone) begin
            cmd.index <= frame[45:40];
            cmd.arg   <= frame[39:8];
        end
    end

    // Host keeps the line idle while the card answers
    hostQuiet: assert property (@(posedge clk) disable iff (!rst_)
        busy |-> !active);

endmodule

`default_nettype wire

//--- rtl/sdCmdHandler.sv
`default_nettype none

module sdCmdHandler import sdCardPkg::*; (
    input  logic  clk,
    input  logic  rst_,
    sdCmdIf.exec  cmd,
    sdRespIf.exec resp,
    output logic  error
);

    logic     appCmd;
    rcaT      rca;
    cmdCodeT  code;
    logic     respond;
    logic     reject;
    cmdIndexT respIndex;
    cmdArgT   respArg;
    logic     respNoCrc;
    logic     respData;

    assign code = {appCmd, cmd.index};

    // ==============================
    // Command lookup
    // ==============================
    always_comb begin
        respond   = 1'b0;
        reject    = 1'b0;
        respIndex = cmd.index;
        respArg   = '0;
        respNoCrc = 1'b0;
        respData  = 1'b0;
        case (code)
            // Back to idle, the host expects nothing
            cmd0: respond = 1'b0;
            cmd3: begin
                respond = 1'b1;
                respArg = {cardRca, r6Status};
            end
            cmd6: begin
                respond  = 1'b1;
                respArg  = r1Cmd6;
                respData = 1'b1;
            end
            cmd7: begin
                if (cmd.arg[31:16] == rca) begin
                    respond = 1'b1;
                    respArg = r1Cmd7;
                end else begin
                    reject = 1'b1;
                end
            end
            cmd8: begin
                respond = 1'b1;
                // Voltage field and check pattern
                respArg = {20'd0, cmd.arg[11:0]};
            end
            cmd55: begin
                respond = 1'b1;
                respArg = r1Cmd55;
            end
            acmd41: begin
                respond   = 1'b1;
                respIndex = r3Index;
                respArg   = ocrReady;
                respNoCrc = 1'b1;
            end
            default: reject = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            appCmd     <= 1'b0;
            rca        <= '0;
            resp.start <= 1'b0;
            error      <= 1'b0;
        end else begin
            resp.start <= cmd.valid && respond;
            error      <= cmd.bad || (cmd.valid && reject);
            if (cmd.valid) begin
                appCmd <= (code == cmd55);
                if (code == cmd0) begin
                    rca <= '0;
                end else if (code == cmd3) begin
                    rca <= cardRca;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            resp.index    <= respIndex;
            resp.arg      <= respArg;
            resp.noCrc    <= respNoCrc;
            resp.withData <= respData;
        end
    end

    startOrError: assert property (@(posedge clk) disable iff (!rst_)
        !(resp.start && error));

endmodule

`default_nettype wire

//--- rtl/sdRespSend.sv
`default_nettype none

module sdRespSend import sdCardPkg::*; (
    input  logic  clk,
    input  logic  rst_,
    sdRespIf.send resp,
    output logic  cmdOut,
    output logic  cmdOe,
    output logic  respDone
);

    typedef enum logic [1:0] {sIdle, sGap, sSend} stateT;

    stateT              state;
    logic [3:0]         gapCnt;
    logic [5:0]         bitCnt;
    logic [5:0]         outIdx;
    logic [bodyLen-1:0] body;
    logic               noCrc;
    logic               nextBit;
    logic               loadBit;
    crc7T               crc;

    // Position of the bit that goes onto the line at the next edge
    assign outIdx  = (state == sSend) ? bitCnt + 6'd1 : 6'd0;
    assign loadBit = ((state == sGap) && (gapCnt == 4'd0))
                  || ((state == sSend) && (bitCnt != 6'(frameLen - 1)));

    always_comb begin
        if (outIdx < 6'(bodyLen)) begin
            nextBit = body[bodyLen-1];
        end else if (outIdx < 6'(frameLen - 1)) begin
            // R3 carries all ones in place of the CRC
            nextBit = noCrc || crc[$bits(crc7T)-1];
        end else begin
            nextBit = 1'b1;
        end
    end

    sdCrc #(
        .crcT (crc7T),
        .poly (crc7Poly)
    ) u_crc7 (
        .clk   (clk),
        .rst_  (rst_),
        .clear (state == sIdle),
        .en    (loadBit && (outIdx < 6'(frameLen - 1))),
        .din   (nextBit),
        .crc   (crc)
    );

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state    <= sIdle;
            gapCnt   <= '0;
            bitCnt   <= '0;
            cmdOut   <= 1'b1;
            cmdOe    <= 1'b0;
            respDone <= 1'b0;
        end else begin
            respDone <= 1'b0;
            case (state)
                sIdle: begin
                    if (resp.start) begin
                        state  <= sGap;
                        gapCnt <= 4'(respGap - 2);
                    end
                end
                sGap: begin
                    if (gapCnt == 4'd0) begin
                        state  <= sSend;
                        bitCnt <= '0;
                        cmdOe  <= 1'b1;
                        cmdOut <= nextBit;
                    end else begin
                        gapCnt <= gapCnt - 4'd1;
                    end
                end
                default: begin
                    if (bitCnt == 6'(frameLen - 1)) begin
                        state    <= sIdle;
                        cmdOe    <= 1'b0;
                        cmdOut   <= 1'b1;
                        respDone <= 1'b1;
                    end else begin
                        bitCnt <= bitCnt + 6'd1;
                        cmdOut <= nextBit;
                    end
                end
            endcase
        end
    end

    // Frame body shifts out MSB first
    always_ff @(posedge clk) begin
        if (state == sIdle && resp.start) begin
            body  <= {2'b00, resp.index, resp.arg};
            noCrc <= resp.noCrc;
        end else if (loadBit) begin
            body <= {body[bodyLen-2:0], 1'b0};
        end
    end

    noOverlap: assert property (@(posedge clk) disable iff (!rst_)
        resp.start |-> state == sIdle);

endmodule

`default_nettype wire

//--- rtl/sdDatSend.sv
`default_nettype none

module sdDatSend import sdCardPkg::*; (
    input  logic       clk,
    input  logic       rst_,
    sdRespIf.data      resp,
    input  logic       respDone,
    output logic [3:0] datOut,
    output logic       datOe
);

    logic       pending;
    logic [7:0] cnt;
    logic [7:0] nextCnt;
    logic [3:0] nextNibble;
    logic [3:0] crcMsb;
    logic       crcEn;
    crc16T      laneCrc [4];

    assign nextCnt = cnt + 8'd1;
    // Payload nibbles feed the CRC, CRC nibbles shift it out
    assign crcEn   = datOe && (nextCnt <= 8'(datNibbles + $bits(crc16T)));

    always_comb begin
        if (nextCnt <= 8'(datNibbles)) begin
            // Status block is all ones
            nextNibble = 4'hF;
        end else if (nextCnt <= 8'(datNibbles + $bits(crc16T))) begin
            nextNibble = crcMsb;
        end else begin
            nextNibble = 4'hF;
        end
    end

    // ==============================
    // One CRC16 per DAT lane
    // ==============================
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        sdCrc #(
            .crcT (crc16T),
            .poly (crc16Poly)
        ) u_crc16 (
            .clk   (clk),
            .rst_  (rst_),
            .clear (!datOe),
            .en    (crcEn),
            .din   (nextNibble[lane]),
            .crc   (laneCrc[lane])
        );
        assign crcMsb[lane] = laneCrc[lane][$bits(crc16T)-1];
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            pending <= 1'b0;
            datOe   <= 1'b0;
            datOut  <= 4'hF;
            cnt     <= '0;
        end else begin
            if (resp.start) begin
                pending <= resp.withData;
            end
            if (respDone && pending) begin
                // Start nibble
                pending <= 1'b0;
                datOe   <= 1'b1;
                datOut  <= 4'h0;
                cnt     <= '0;
            end else if (datOe) begin
                if (cnt == 8'(datCycles - 1)) begin
                    datOe  <= 1'b0;
                    datOut <= 4'hF;
                    cnt    <= '0;
                end else begin
                    cnt    <= nextCnt;
                    datOut <= nextNibble;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sdCard.sv
`default_nettype none

module sdCard (
    input  logic       clk,
    input  logic       rst_,
    input  logic       cmdIn,
    output logic       cmdOut,
    output logic       cmdOe,
    output logic [3:0] datOut,
    output logic       datOe,
    output logic       error
);

    logic respDone;

    sdCmdIf  cmdBus ();
    sdRespIf respBus ();

    // Receiver ignores the command line while the card drives it
    sdCmdReceive u_receive (
        .clk   (clk),
        .rst_  (rst_),
        .cmdIn (cmdIn),
        .busy  (cmdOe),
        .cmd   (cmdBus.rx)
    );

    sdCmdHandler u_handler (
        .clk   (clk),
        .rst_  (rst_),
        .cmd   (cmdBus.exec),
        .resp  (respBus.exec),
        .error (error)
    );

    sdRespSend u_respSend (
        .clk      (clk),
        .rst_     (rst_),
        .resp     (respBus.send),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .respDone (respDone)
    );

    sdDatSend u_datSend (
        .clk      (clk),
        .rst_     (rst_),
        .resp     (respBus.data),
        .respDone (respDone),
        .datOut   (datOut),
        .datOe    (datOe)
    );

endmodule

`default_nettype wire

//--- tests/tbClock.sv
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst_
);

    localparam int halfPeriod  = 50;
    localparam int resetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        rst_ <= 1'b0;
        repeat (resetCycles) @(posedge clk);
        rst_ <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/sdCardTb.sv
`default_nettype none

module sdCardTb;

    // ==============================
    // Limits and timing
    // ==============================
    localparam int maxTests      = 32;
    localparam int resetCycles   = 10;
    localparam int cyclesPerTest = 400;
    // Cycles after the end bit is sampled
    localparam int respLatency   = 4;
    localparam int errLatency    = 2;
    localparam int frameBits     = 48;
    localparam int datBeats      = 146;
    localparam int quietCycles   = 60;
    localparam int kindNone      = 0;
    localparam int kindResp      = 1;
    localparam int kindError     = 2;

    logic       clk;
    logic       rst_;
    logic       cmdIn;
    logic       cmdOut;
    logic       cmdOe;
    logic [3:0] datOut;
    logic       datOe;
    logic       error;

    logic [127:0] testName [maxTests];
    logic [5:0]   cmdIndex [maxTests];
    logic [31:0]  cmdArg   [maxTests];
    logic         badCrc   [maxTests];
    int           kindCode [maxTests];
    logic [5:0]   expIndex [maxTests];
    logic [31:0]  expArg   [maxTests];
    logic         expData  [maxTests];
    int           numTests    = 0;
    logic         testsLoaded = 1'b0;

    tbClock u_clock (
        .clk  (clk),
        .rst_ (rst_)
    );

    sdCard u_sdCard (
        .clk    (clk),
        .rst_   (rst_),
        .cmdIn  (cmdIn),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe),
        .datOut (datOut),
        .datOe  (datOe),
        .error  (error)
    );

    // CRC7 x^7 + x^3 + 1, MSB first, zero start
    function automatic logic [6:0] crc7Of(input logic [39:0] body);
        logic [6:0]  crc;
        logic [39:0] bits;
        logic        fb;
        crc  = '0;
        bits = body;
        repeat (40) begin
            fb   = bits[39] ^ crc[6];
            crc  = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
            bits = {bits[38:0], 1'b0};
        end
        return crc;
    endfunction

    // CRC16 x^16 + x^12 + x^5 + 1 over a run of ones
    function automatic logic [15:0] onesCrc16(input int nBits);
        logic [15:0] crc;
        logic        fb;
        crc = '0;
        repeat (nBits) begin
            fb  = 1'b1 ^ crc[15];
            crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
        return crc;
    endfunction

    task automatic stopRun(input string why);
        $display("%0s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input logic [127:0] name, input string what,
                         input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            stopRun($sformatf("Fail %0s %0s: expected %h, actual %h",
                              name, what, expected, actual));
        end
    endtask

    task automatic loadTests();
        int            fd;
        int            got;
        logic [767:0]  lineBuf;
        logic [127:0]  nm;
        logic [63:0]   kind;
        logic [5:0]    idx;
        logic [5:0]    ei;
        logic [31:0]   arg;
        logic [31:0]   ea;
        logic          bad;
        logic          ed;
        fd = $fopen("tests/sdCardInput.txt", "r");
        if (fd == 0) begin
            stopRun("Cannot open the test file tests/sdCardInput.txt");
        end
        while (!$feof(fd) && numTests < maxTests) begin
            lineBuf = '0;
            got = $fgets(lineBuf, fd);
            // Comment and blank lines do not yield all eight fields
            if (got > 0) begin
                got = $sscanf(lineBuf, "%s %h %h %h %s %h %h %h",
                              nm, idx, arg, bad, kind, ei, ea, ed);
                if (got == 8) begin
                    testName[numTests] = nm;
                    cmdIndex[numTests] = idx;
                    cmdArg[numTests]   = arg;
                    badCrc[numTests]   = bad;
                    expIndex[numTests] = ei;
                    expArg[numTests]   = ea;
                    expData[numTests]  = ed;
                    if (kind == 64'("resp")) begin
                        kindCode[numTests] = kindResp;
                    end else if (kind == 64'("error")) begin
                        kindCode[numTests] = kindError;
                    end else if (kind == 64'("none")) begin
                        kindCode[numTests] = kindNone;
                    end else begin
                        stopRun($sformatf("Unknown expected kind in test %0s", nm));
                    end
                    numTests++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Returns on the edge that samples the end bit
    task automatic sendFrame(input int t);
        logic [39:0] body;
        logic [6:0]  crc;
        logic [47:0] frame;
        body = {2'b01, cmdIndex[t], cmdArg[t]};
        crc  = crc7Of(body);
        if (badCrc[t]) begin
            crc = crc ^ 7'h01;
        end
        frame = {body, crc, 1'b1};
        repeat (frameBits) begin
            @(posedge clk);
            cmdIn <= frame[47];
            frame = {frame[46:0], 1'b0};
        end
        @(posedge clk);
        cmdIn <= 1'b1;
    endtask

    task automatic expectResponse(input int t);
        logic [39:0] body;
        logic [47:0] want;
        logic [47:0] got;
        logic [15:0] laneCrc;
        logic [3:0]  wantNib;
        int          lat;
        int          len;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            check(testName[t], "error", 64'(0), 64'(error));
        end while (!cmdOe && lat <= quietCycles);
        if (!cmdOe) begin
            stopRun($sformatf("No response to test %0s within %0d cycles",
                              testName[t], quietCycles));
        end
        check(testName[t], "response latency", 64'(respLatency), 64'(lat - 1));
        got = '0;
        len = 0;
        while (cmdOe && len <= frameBits) begin
            got = {got[46:0], cmdOut};
            len++;
            @(negedge clk);
        end
        check(testName[t], "cmdOe cycles", 64'(frameBits), 64'(len));
        body = {2'b00, expIndex[t], expArg[t]};
        // R3 carries all ones in the CRC field
        if (expIndex[t] == 6'h3F) begin
            want = {body, 7'h7F, 1'b1};
        end else begin
            want = {body, crc7Of(body), 1'b1};
        end
        check(testName[t], "response frame", 64'(want), 64'(got));
        @(negedge clk);
        check(testName[t], "datOe after response", 64'(expData[t]), 64'(datOe));
        if (expData[t]) begin
            // Every lane carries the same all ones payload
            laneCrc = onesCrc16(128);
            len = 0;
            while (datOe && len <= datBeats) begin
                if (len == 0) begin
                    wantNib = 4'h0;
                end else if (len <= 128 || len == datBeats - 1) begin
                    wantNib = 4'hF;
                end else begin
                    wantNib = {4{laneCrc[15]}};
                    laneCrc = {laneCrc[14:0], 1'b0};
                end
                check(testName[t], $sformatf("DAT beat %0d", len), 64'(wantNib), 64'(datOut));
                len++;
                @(negedge clk);
            end
            check(testName[t], "datOe cycles", 64'(datBeats), 64'(len));
        end
    endtask

    task automatic watchQuiet(input int t, input logic wantError);
        int errCount;
        int errAt;
        errCount = 0;
        errAt    = 0;
        for (int n = 1; n <= quietCycles; n++) begin
            @(negedge clk);
            check(testName[t], "cmdOe", 64'(0), 64'(cmdOe));
            check(testName[t], "datOe", 64'(0), 64'(datOe));
            if (error) begin
                errCount++;
                errAt = n - 1;
            end
        end
        check(testName[t], "error cycles", 64'(wantError), 64'(errCount));
        if (wantError) begin
            check(testName[t], "error latency", 64'(errLatency), 64'(errAt));
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        cmdIn <= 1'b1;
        void'($urandom(32'h6276_5da6));
        loadTests();
        if (numTests == 0) begin
            stopRun("No tests found in tests/sdCardInput.txt");
        end
        testsLoaded = 1'b1;
        wait (rst_ === 1'b1);
        @(posedge clk);
        for (int t = 0; t < numTests; t++) begin
            repeat ($urandom % 8) @(posedge clk);
            sendFrame(t);
            if (kindCode[t] == kindResp) begin
                expectResponse(t);
            end else begin
                watchQuiet(t, kindCode[t] == kindError);
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        wait (testsLoaded);
        repeat (numTests * cyclesPerTest + resetCycles) @(posedge clk);
        stopRun("Watchdog timeout, the tests did not finish in time");
    end

endmodule

`default_nettype wire

//--- tests/sdCardInput.txt
# name index arg badCrc kind respIndex respArg data, numbers in hex
# kind is none, resp or error and respIndex 3F marks an R3 frame
goIdle        00 00000000 0 none  00 00000000 0
ifCond        08 000001AA 0 resp  08 000001AA 0
ifCondHigh    08 12345C3A 0 resp  08 00000C3A 0
acmdNo55      29 40FF8000 0 error 00 00000000 0
appCmd        37 00000000 0 resp  37 00000120 0
opCond        29 40FF8000 0 resp  3F C1FF8080 0
selBeforeRca  07 AAAA0000 0 error 00 00000000 0
relAddr       03 00000000 0 resp  03 AAAA0520 0
selWrong      07 12340000 0 error 00 00000000 0
selCard       07 AAAA0000 0 resp  07 00000700 0
crcBad        08 000001AA 1 error 00 00000000 0
unknownCmd    05 00000000 0 error 00 00000000 0
switchFunc    06 80FFFFF1 0 resp  06 00000900 1
goIdleAgain   00 00000000 0 none  00 00000000 0
selAfterIdle  07 AAAA0000 0 error 00 00000000 0
appCmdAgain   37 00000000 0 resp  37 00000120 0
opCondAgain   29 00FF8000 0 resp  3F C1FF8080 0
ifCondLast    08 000002AA 0 resp  08 000002AA 0

//--- project.f
rtl/sdCardPkg.sv
rtl/sdCmdIf.sv
rtl/sdCrc.sv
rtl/sdCmdReceive.sv
rtl/sdCmdHandler.sv
rtl/sdRespSend.sv
rtl/sdDatSend.sv
rtl/sdCard.sv
tests/tbClock.sv
tests/sdCardTb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module sdCardTb -f project.f -o sdCardSim \
    && ./obj_dir/sdCardSim > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
